// File: bench/patch_scan_asserts.sv
module patch_scan_asserts (
  input  logic              clk,
  input  logic              rst,
  input  logic              win_valid,
  input  logic              pix_ready,
  input  patch_pkg::score_t score,
  input  logic              score_valid,
  input  logic              score_ready,
  input  logic              frame_done
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // ****************************************
  // output handshake
  // ****************************************
  a_score_stable: assert property (
    @(posedge clk) disable iff (rst)
    score_valid && !score_ready |=> score_valid && $stable(score)
  )
  else
  begin
    fail_count++;
    $error("score or score_valid changed while the output was stalled");
  end

  // ****************************************
  // input handshake and end of frame
  // ****************************************

  // input stalls only behind a held window and a stalled output
  a_ready_idle: assert property (
    @(posedge clk) disable iff (rst)
    !pix_ready |-> win_valid && score_valid && !score_ready
  )
  else
  begin
    fail_count++;
    $error("pix_ready low without a held window and a stalled output");
  end

  a_done_pulse: assert property (
    @(posedge clk) disable iff (rst)
    frame_done |=> !frame_done
  )
  else
  begin
    fail_count++;
    $error("frame_done high for two cycles in a row");
  end

endmodule

bind patch_scan_top patch_scan_asserts u_patch_scan_asserts (
  .clk         (clk),
  .rst         (rst),
  .win_valid   (win_valid),
  .pix_ready   (pix_ready),
  .score       (score),
  .score_valid (score_valid),
  .score_ready (score_ready),
  .frame_done  (frame_done)
);

// File: bench/patch_scan_tb.sv
module patch_scan_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [patch_pkg::frame_lines-1:0][patch_pkg::line_pixels-1:0] frame_t;

  localparam int frame_windows = (patch_pkg::frame_lines - patch_pkg::win_size + 1)
                               * (patch_pkg::line_pixels - patch_pkg::win_size + 1);
  localparam int frame_count = 7;
  localparam int timeout_cycles = 6 * patch_pkg::line_pixels * patch_pkg::frame_lines
                                * frame_count;

  logic              clk;
  logic              rst;
  logic              pix;
  logic              pix_valid;
  logic              pix_ready;
  patch_pkg::score_t score;
  logic              score_valid;
  logic              score_ready;
  logic              frame_done;

  patch_pkg::score_t exp_q [$];
  int                errors;
  int                scores_seen;
  int                windows_queued;
  int                pulses;
  int                cycles;
  int                ready_pct;
  frame_t            img_a;
  frame_t            img_b;

  patch_scan_top u_patch_scan_top (
    .clk         (clk),
    .rst         (rst),
    .pix         (pix),
    .pix_valid   (pix_valid),
    .pix_ready   (pix_ready),
    .score       (score),
    .score_valid (score_valid),
    .score_ready (score_ready),
    .frame_done  (frame_done)
  );

  always #2 clk = ~clk;

  // ****************************************
  // reference model and checks
  // ****************************************
  function automatic patch_pkg::score_t expected_score(input frame_t img, input int line,
                                                       input int col);
    int n;
    n = 0;
    for (int l = line - patch_pkg::win_size + 1; l <= line; l++)
    begin
      for (int c = col - patch_pkg::win_size + 1; c <= col; c++)
      begin
        n += img[l][c];
      end
    end
    return patch_pkg::score_t'(n);
  endfunction

  function automatic frame_t random_frame();
    frame_t f;
    for (int l = 0; l < patch_pkg::frame_lines; l++)
    begin
      for (int c = 0; c < patch_pkg::line_pixels; c++)
      begin
        f[l][c] = $urandom_range(1);
      end
    end
    return f;
  endfunction

  task automatic check_score(input string name, input patch_pkg::score_t got,
                             input patch_pkg::score_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_pulse(input string name, input int got, input int exp);
    if (got != exp)
    begin
      errors++;
      $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      errors++;
      $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // ****************************************
  // stimulus
  // ****************************************
  task automatic send_frame(input frame_t img, input int gap_pct);
    for (int l = 0; l < patch_pkg::frame_lines; l++)
    begin
      for (int c = 0; c < patch_pkg::line_pixels; c++)
      begin
        while ($urandom_range(99) < gap_pct)
        begin
          pix_valid = 1'b0;
          pix = $urandom_range(1);
          @(negedge clk);
        end
        pix = img[l][c];
        pix_valid = 1'b1;
        @(posedge clk);
        while (!pix_ready)
          @(posedge clk);
        // this pixel completed a window
        if (l >= patch_pkg::win_size - 1 && c >= patch_pkg::win_size - 1)
        begin
          exp_q.push_back(expected_score(img, l, c));
          windows_queued++;
        end
        @(negedge clk);
      end
    end
    pix_valid = 1'b0;
  endtask

  // output has gone quiet once no score is offered for a while
  task automatic wait_drain();
    int quiet;
    quiet = 0;
    while (quiet < 8)
    begin
      @(negedge clk);
      if (score_valid)
        quiet = 0;
      else
        quiet++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before, input int seen_before,
                             input int exp_scores);
    check_count("scores received", scores_seen - seen_before, exp_scores);
    check_count("scores left in queue", exp_q.size(), 0);
    if (errors == errs_before)
      $display("%s: ok, %0d scores", name, exp_scores);
    else
      $display("%s: %0d errors", name, errors - errs_before);
  endtask

  always @(negedge clk)
  begin
    if (ready_pct >= 100)
      score_ready = 1'b1;
    else
      score_ready = ($urandom_range(99) < ready_pct);
  end

  // compare each output transfer with the oldest expected score
  always @(posedge clk)
  begin
    if (!rst && score_valid && score_ready)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("error at %0t ns: score %0d arrived with nothing expected", $time, score);
      end
      else
        check_score("score", score, exp_q.pop_front());
      scores_seen++;
    end
    if (!rst && frame_done)
    begin
      pulses++;
      check_pulse("windows queued at frame_done", windows_queued, frame_windows * pulses);
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > timeout_cycles)
    begin
      $display("timeout: run did not end within %0d cycles", timeout_cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // ****************************************
  // test sequence
  // ****************************************
  initial
  begin
    int seed;
    int e0;
    int s0;
    int p0;
    int fails;
    clk = 1'b0;
    rst = 1'b1;
    pix = 1'b0;
    pix_valid = 1'b0;
    score_ready = 1'b1;
    ready_pct = 100;
    errors = 0;
    scores_seen = 0;
    windows_queued = 0;
    pulses = 0;
    cycles = 0;
    seed = $urandom(67517);
    repeat (8) @(negedge clk);
    rst = 1'b0;
    if (pix_ready !== 1'b1 || score_valid !== 1'b0 || frame_done !== 1'b0)
    begin
      errors++;
      $display("error at %0t ns: outputs not idle after reset", $time);
    end

    e0 = errors;
    s0 = scores_seen;
    img_a = random_frame();
    send_frame(img_a, 0);
    wait_drain();
    report_test("test 1 random frame", e0, s0, frame_windows);

    e0 = errors;
    s0 = scores_seen;
    img_b = '0;
    send_frame(img_b, 0);
    img_b = '1;
    send_frame(img_b, 0);
    wait_drain();
    report_test("test 2 all-zero and all-one frames", e0, s0, 2 * frame_windows);

    e0 = errors;
    s0 = scores_seen;
    ready_pct = 50;
    img_b = random_frame();
    send_frame(img_b, 0);
    wait_drain();
    ready_pct = 100;
    report_test("test 3 output back-pressure", e0, s0, frame_windows);

    // same image as test 1, with input gaps
    e0 = errors;
    s0 = scores_seen;
    send_frame(img_a, 40);
    wait_drain();
    report_test("test 4 input gaps", e0, s0, frame_windows);

    e0 = errors;
    s0 = scores_seen;
    p0 = pulses;
    img_a = random_frame();
    img_b = random_frame();
    send_frame(img_a, 0);
    send_frame(img_b, 0);
    wait_drain();
    check_pulse("frame_done pulses", pulses - p0, 2);
    report_test("test 5 two frames back to back", e0, s0, 2 * frame_windows);

    fails = u_patch_scan_top.u_patch_scan_asserts.fail_count;
    $display("summary: 5 tests, %0d scores, %0d errors, %0d assertion failures",
             scores_seen, errors, fails);
    if (errors == 0 && fails == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: compile.f
src/patch_pkg.sv
src/line_delay.sv
src/window_array.sv
src/scan_ctrl.sv
src/window_score.sv
src/patch_scan_top.sv
bench/patch_scan_asserts.sv
bench/patch_scan_tb.sv

// File: src/line_delay.sv
module line_delay (
  input  logic clk,
  input  logic en,
  input  logic d,
  output logic q
);

  logic [patch_pkg::delay_depth-1:0] taps;

  // advances with the window rows, one stage per accepted pixel
  always_ff @(posedge clk)
  begin
    if (en)
    begin
      taps <= {taps[patch_pkg::delay_depth-2:0], d};
    end
  end

  // oldest pixel leaves here
  assign q = taps[patch_pkg::delay_depth-1];

endmodule

// File: src/patch_pkg.sv
package patch_pkg;

  // ****************************************
  // frame and window geometry
  // ****************************************
  localparam int win_size = 24;
  localparam int line_pixels = 64;
  localparam int frame_lines = 32;

  // row register plus its delay spans one line
  localparam int delay_depth = line_pixels - win_size;
  localparam int win_bits = win_size * win_size;

  // ****************************************
  // data types
  // ****************************************
  typedef logic [win_size-1:0] win_row_t;
  typedef logic [win_bits-1:0] window_t;

  typedef logic [$clog2(line_pixels)-1:0] col_t;
  typedef logic [$clog2(frame_lines)-1:0] line_t;

  // counts up to win_size and win_bits inclusive
  typedef logic [$clog2(win_size+1)-1:0] row_sum_t;
  typedef logic [$clog2(win_bits+1)-1:0] score_t;

  typedef enum logic [1:0] {
    st_fill,
    st_edge,
    st_scan
  } scan_state_t;

endpackage

// File: src/patch_scan_top.sv
module patch_scan_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              pix,
  input  logic              pix_valid,
  output logic              pix_ready,
  output patch_pkg::score_t score,
  output logic              score_valid,
  input  logic              score_ready,
  output logic              frame_done
);

  patch_pkg::window_t window;
  logic               shift_en;
  logic               win_valid;
  logic               win_ready;
  logic               win_taken;

  // ****************************************
  // input handshake
  // ****************************************

  // never shift while a held window is still waiting
  assign pix_ready = !win_valid || win_ready;
  assign shift_en = pix_valid && pix_ready;
  assign win_taken = win_valid && win_ready;

  // ****************************************
  // datapath
  // ****************************************
  window_array u_window_array (
    .clk      (clk),
    .rst      (rst),
    .shift_en (shift_en),
    .pix      (pix),
    .window   (window)
  );

  scan_ctrl u_scan_ctrl (
    .clk        (clk),
    .rst        (rst),
    .shift_en   (shift_en),
    .win_valid  (win_valid),
    .win_taken  (win_taken),
    .frame_done (frame_done)
  );

  // scores leave two cycles after the window completes
  window_score u_window_score (
    .clk         (clk),
    .rst         (rst),
    .window      (window),
    .win_valid   (win_valid),
    .win_ready   (win_ready),
    .score       (score),
    .score_valid (score_valid),
    .score_ready (score_ready)
  );

endmodule

// File: src/scan_ctrl.sv
module scan_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic shift_en,
  output logic win_valid,
  input  logic win_taken,
  output logic frame_done
);

  patch_pkg::col_t        col;
  patch_pkg::line_t       line;
  patch_pkg::col_t        next_col;
  patch_pkg::line_t       next_line;
  patch_pkg::scan_state_t state;
  patch_pkg::scan_state_t next_state;
  logic                   last_col;
  logic                   last_line;

  assign last_col = (col == patch_pkg::col_t'(patch_pkg::line_pixels - 1));
  assign last_line = (line == patch_pkg::line_t'(patch_pkg::frame_lines - 1));

  // ****************************************
  // position of the next pixel
  // ****************************************
  always_comb
  begin
    next_col = col + patch_pkg::col_t'(1);
    next_line = line;
    if (last_col)
    begin
      next_col = '0;
      if (last_line)
        next_line = '0;
      else
        next_line = line + patch_pkg::line_t'(1);
    end

    // state describes the pixel that will be accepted next
    if (next_line < patch_pkg::line_t'(patch_pkg::win_size - 1))
      next_state = patch_pkg::st_fill;
    else if (next_col < patch_pkg::col_t'(patch_pkg::win_size - 1))
      next_state = patch_pkg::st_edge;
    else
      next_state = patch_pkg::st_scan;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      col <= '0;
      line <= '0;
      state <= patch_pkg::st_fill;
    end
    else if (shift_en)
    begin
      col <= next_col;
      line <= next_line;
      state <= next_state;
    end
  end

  // ****************************************
  // window valid and end of frame
  // ****************************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      win_valid <= 1'b0;
      frame_done <= 1'b0;
    end
    else
    begin
      // a new window may replace one taken in the same cycle
      if (shift_en && state == patch_pkg::st_scan)
        win_valid <= 1'b1;
      else if (win_taken)
        win_valid <= 1'b0;

      frame_done <= shift_en && last_col && last_line;
    end
  end

endmodule

// File: src/window_array.sv
module window_array (
  input  logic               clk,
  input  logic               rst,
  input  logic               shift_en,
  input  logic               pix,
  output patch_pkg::window_t window
);

  // rows[0] holds the current line, rows[23] the oldest
  patch_pkg::win_row_t rows [patch_pkg::win_size];

  // serial input of each row
  logic row_in [patch_pkg::win_size];

  assign row_in[0] = pix;

  // ****************************************
  // row shift registers
  // ****************************************
  genvar r;
  generate
    for (r = 0; r < patch_pkg::win_size; r++)
    begin : g_row
      always_ff @(posedge clk)
      begin
        if (rst)
        begin
          rows[r] <= '0;
        end
        else if (shift_en)
        begin
          // new pixel enters at the top bit
          rows[r] <= {row_in[r], rows[r][patch_pkg::win_size-1:1]};
        end
      end

      assign window[r*patch_pkg::win_size +: patch_pkg::win_size] = rows[r];
    end
  endgenerate

  // ****************************************
  // line delays between rows
  // ****************************************
  genvar k;
  generate
    for (k = 0; k < patch_pkg::win_size - 1; k++)
    begin : g_delay
      line_delay u_line_delay (
        .clk (clk),
        .en  (shift_en),
        .d   (rows[k][0]),
        .q   (row_in[k+1])
      );
    end
  endgenerate

endmodule

// File: src/window_score.sv
module window_score (
  input  logic               clk,
  input  logic               rst,
  input  patch_pkg::window_t window,
  input  logic               win_valid,
  output logic               win_ready,
  output patch_pkg::score_t  score,
  output logic               score_valid,
  input  logic               score_ready
);

  patch_pkg::row_sum_t row_cnt [patch_pkg::win_size];
  patch_pkg::row_sum_t s1_sum [patch_pkg::win_size];
  patch_pkg::score_t   total;
  logic                s1_valid;
  logic                s1_load;
  logic                s2_load;

  function automatic patch_pkg::row_sum_t row_count(input patch_pkg::win_row_t row);
    patch_pkg::row_sum_t n;
    n = '0;
    for (int i = 0; i < patch_pkg::win_size; i++)
    begin
      n = n + patch_pkg::row_sum_t'(row[i]);
    end
    return n;
  endfunction

  // a stage loads when empty or when drained this cycle
  assign s2_load = !score_valid || score_ready;
  assign s1_load = !s1_valid || s2_load;
  assign win_ready = s1_load;

  // ****************************************
  // stage 1, per-row counts
  // ****************************************
  always_comb
  begin
    for (int r = 0; r < patch_pkg::win_size; r++)
    begin
      row_cnt[r] = row_count(window[r*patch_pkg::win_size +: patch_pkg::win_size]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      s1_valid <= 1'b0;
    else if (s1_load)
      s1_valid <= win_valid;
  end

  always_ff @(posedge clk)
  begin
    if (s1_load && win_valid)
      s1_sum <= row_cnt;
  end

  // ****************************************
  // stage 2, window total
  // ****************************************
  always_comb
  begin
    total = '0;
    for (int r = 0; r < patch_pkg::win_size; r++)
    begin
      total = total + patch_pkg::score_t'(s1_sum[r]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      score_valid <= 1'b0;
    else if (s2_load)
      score_valid <= s1_valid;
  end

  always_ff @(posedge clk)
  begin
    if (s2_load && s1_valid)
      score <= total;
  end

endmodule
